//--- logic/tlp_pkg.sv
/* TLP handler shared definitions
   Field widths, fmt/type codes, CSR map and the records passed between blocks */
`default_nettype none

package tlp_pkg;

  localparam int DW_BITS       = 32;
  localparam int BEAT_DWORDS   = 8;
  localparam int BEAT_BITS     = DW_BITS * BEAT_DWORDS; // 256-bit Avalon-ST
  localparam int EMPTY_BITS    = 5;
  localparam int ID_BITS       = 16;
  localparam int TAG_BITS      = 8;
  localparam int LEN_BITS      = 10;
  localparam int BC_BITS       = 12;
  localparam int BAR_ADDR_BITS = 16; // 64 KiB region
  localparam int CSR_ADDR_BITS = 6;

  // {fmt[1], type}
  localparam logic [5:0] FMT_TYPE_MRD   = 6'b000000;
  localparam logic [5:0] FMT_TYPE_MRDLK = 6'b000001;
  localparam logic [5:0] FMT_TYPE_MWR   = 6'b100000;
  localparam logic [5:0] FMT_TYPE_CPL   = 6'b001010;
  localparam logic [5:0] FMT_TYPE_CPLD  = 6'b101010;

  localparam logic [2:0] CPL_STATUS_SC = 3'b000;
  localparam logic [2:0] CPL_STATUS_UR = 3'b001;

  localparam int CPL_ERR_UR_P_BIT  = 4; // UR on posted request
  localparam int CPL_ERR_UR_NP_BIT = 5; // UR on non-posted request

  localparam logic [CSR_ADDR_BITS-1:0] CSR_STATUS            = 6'd0;
  localparam logic [CSR_ADDR_BITS-1:0] CSR_RX_COUNT          = 6'd1;
  localparam logic [CSR_ADDR_BITS-1:0] CSR_RX_UNSUP_COUNT    = 6'd2;
  localparam logic [CSR_ADDR_BITS-1:0] CSR_TX_INSTANT_COUNT  = 6'd3;
  localparam logic [CSR_ADDR_BITS-1:0] CSR_TX_RESPONSE_COUNT = 6'd4;
  localparam logic [DW_BITS-1:0]       CSR_UNMAPPED          = '1;

  typedef enum logic [2:0] {UNKNOWN, MRD, MRDLK, MWR, CPL, CPLD} tlp_kind_e;

  typedef struct packed {
    logic [BEAT_BITS-1:0]  data;  // Dword 0 in the top bits
    logic [EMPTY_BITS-1:0] empty;
    logic                  sop;
    logic                  eop;
  } rx_beat_t;

  typedef struct packed {
    logic [BEAT_BITS-1:0]  data;
    logic [EMPTY_BITS-1:0] empty;
    logic                  valid;
    logic                  sop;
    logic                  eop;
  } tx_beat_t;

  typedef struct packed {
    tlp_kind_e              kind;
    logic [ID_BITS-1:0]     requester_id;
    logic [TAG_BITS-1:0]    tag;
    logic [BAR_ADDR_BITS-1:0] addr; // Byte address within region
    logic [DW_BITS-1:0]     data;
    logic [LEN_BITS-1:0]    len;
    logic [BC_BITS-1:0]     byte_count;
    logic                   is_npr;
    logic                   is_pr;
    logic                   unsupported;
  } rx_frame_t;

  typedef struct packed {
    logic                       is_write;
    logic [ID_BITS-1:0]         requester_id;
    logic [TAG_BITS-1:0]        tag;
    logic [BAR_ADDR_BITS-3:0]   dw_addr;
    logic [DW_BITS-1:0]         data;
  } mem_req_t;

  typedef struct packed {
    logic [ID_BITS-1:0]  requester_id;
    logic [TAG_BITS-1:0] tag;
    logic [4:0]          lower_addr; // Dword bits of lower address
    logic [DW_BITS-1:0]  rddata;
  } mem_resp_t;

  typedef struct packed {
    logic                has_data;
    logic [2:0]          status;
    logic [BC_BITS-1:0]  byte_count;
    logic [ID_BITS-1:0]  requester_id;
    logic [TAG_BITS-1:0] tag;
    logic [6:0]          lower_addr;
    logic [DW_BITS-1:0]  data;
  } cpl_fields_t;

endpackage

`default_nettype wire

//--- logic/tlp_rx_decode.sv
/* RX header decoder
   Captures 3DW request headers on sop into a frame record with byte count and UR flag */
`default_nettype none

module tlp_rx_decode (
  input  logic               clk,
  input  logic               reset,
  input  logic               accept,
  input  tlp_pkg::rx_beat_t  rx_st,
  output tlp_pkg::rx_frame_t frame,
  output logic               frame_start,
  output logic               frame_end,
  output logic [6:0]         cpl_err
);
  import tlp_pkg::*;

  logic [BEAT_DWORDS-1:0][DW_BITS-1:0] dw; // dw[0] is the first header dword
  logic [5:0]          code;
  logic                is_4dw;
  logic [LEN_BITS-1:0] len;
  logic [DW_BITS-1:0]  wr_data;
  logic [BC_BITS-1:0]  byte_count;
  tlp_kind_e           kind;
  logic                is_npr;
  logic                is_pr;
  logic                unsupported;

  // Byte count from Length and first/last byte enables
  function automatic logic [BC_BITS-1:0] calc_byte_count(
      input logic [3:0] first_be,
      input logic [3:0] last_be,
      input logic [LEN_BITS-1:0] len_dw);
    int f_lo;
    int f_hi;
    int l_hi;
    f_lo = 0;
    f_hi = 0;
    l_hi = 0;
    for (int i = 3; i >= 0; i--) begin
      if (first_be[i]) f_lo = i; // Lowest enabled lane
    end
    for (int i = 0; i < 4; i++) begin
      if (first_be[i]) f_hi = i;
      if (last_be[i]) l_hi = i;
    end
    if (first_be == 4'b0000) return '0; // Zero-length read, or invalid
    if (last_be == 4'b0000) return BC_BITS'(f_hi - f_lo + 1); // Single dword
    return BC_BITS'(int'({len_dw, 2'b00}) - f_lo - (3 - l_hi));
  endfunction

  always_comb begin
    for (int i = 0; i < BEAT_DWORDS; i++) begin
      dw[i] = rx_st.data[BEAT_BITS-1-i*DW_BITS -: DW_BITS];
    end
  end

  assign code       = {dw[0][30], dw[0][28:24]}; // fmt[1] and type
  assign is_4dw     = dw[0][29];
  assign len        = dw[0][LEN_BITS-1:0];
  // Qword-aligned address puts data after a pad dword
  assign wr_data    = dw[2][2] ? dw[3] : dw[4];
  assign byte_count = calc_byte_count(dw[1][3:0], dw[1][7:4], len);

  always_comb begin
    case (code)
      FMT_TYPE_MRD:   kind = MRD;
      FMT_TYPE_MRDLK: kind = MRDLK;
      FMT_TYPE_MWR:   kind = MWR;
      FMT_TYPE_CPL:   kind = CPL;
      FMT_TYPE_CPLD:  kind = CPLD;
      default:        kind = UNKNOWN;
    endcase
  end

  // Posted vs non-posted
  always_comb begin
    is_npr = 1'b0;
    is_pr  = 1'b0;
    casez (code)
      6'b00000?, 6'b?00010, 6'b1011??: is_npr = 1'b1; // MRd/MRdLk, IO, atomics
      6'b100000, 6'b?10???:            is_pr  = 1'b1; // MWr, Msg/MsgD
      default: ;
    endcase
  end

  always_comb begin
    unsupported = 1'b0;
    if (kind == UNKNOWN || kind == CPL || kind == MRDLK) begin
      unsupported = 1'b1;
    end else if (is_4dw) begin
      unsupported = 1'b1; // No 64-bit addressing
    end else if (kind == MRD || kind == MWR) begin
      // Only single dword, full or zero-length
      if (len != LEN_BITS'(1) || (byte_count != '0 && byte_count != BC_BITS'(4))) begin
        unsupported = 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      frame_start <= 1'b0;
      frame_end   <= 1'b0;
    end else begin
      frame_start <= accept & rx_st.sop;
      frame_end   <= accept & rx_st.eop;
    end
  end

  // Record holds until next sop
  always_ff @(posedge clk) begin
    if (accept && rx_st.sop) begin
      frame.kind         <= kind;
      frame.requester_id <= dw[1][31:16];
      frame.tag          <= dw[1][15:8];
      frame.addr         <= {dw[2][BAR_ADDR_BITS-1:2], 2'b00}; // Masked to region
      frame.data         <= wr_data;
      frame.len          <= len;
      frame.byte_count   <= byte_count;
      frame.is_npr       <= is_npr;
      frame.is_pr        <= is_pr;
      frame.unsupported  <= unsupported;
    end
  end

  always_comb begin
    cpl_err = '0;
    cpl_err[CPL_ERR_UR_P_BIT]  = frame_start & frame.unsupported & frame.is_pr;
    cpl_err[CPL_ERR_UR_NP_BIT] = frame_start & frame.unsupported & frame.is_npr;
  end

endmodule

`default_nettype wire

//--- logic/tlp_dispatch.sv
/* Request dispatcher
   Routes finished frames to memory or instant completions, memory responses to CplD */
`default_nettype none

module tlp_dispatch (
  input  logic                 clk,
  input  logic                 reset,
  input  tlp_pkg::rx_frame_t   frame,
  input  logic                 frame_end,
  input  tlp_pkg::mem_resp_t   mem_resp,
  input  logic                 mem_resp_valid,
  input  logic                 mem_req_ready,
  output tlp_pkg::mem_req_t    mem_req,
  output logic                 mem_req_valid,
  output tlp_pkg::cpl_fields_t instant,
  output logic                 instant_valid,
  output tlp_pkg::cpl_fields_t response,
  output logic                 response_valid
);
  import tlp_pkg::*;

  logic is_mem;
  logic issue_mem;
  logic issue_instant;

  assign is_mem        = frame.kind == MRD || frame.kind == MWR;
  assign issue_mem     = frame_end & ~frame.unsupported & is_mem & (frame.byte_count != '0);
  // UR or zero-length read, both need a completion now
  assign issue_instant = frame_end & frame.is_npr & (frame.unsupported | (frame.byte_count == '0));

  always_ff @(posedge clk) begin
    if (reset) begin
      mem_req_valid  <= 1'b0;
      instant_valid  <= 1'b0;
      response_valid <= 1'b0;
    end else begin
      mem_req_valid  <= issue_mem;
      instant_valid  <= issue_instant;
      response_valid <= mem_resp_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (issue_mem) begin
      mem_req.is_write     <= frame.kind == MWR;
      mem_req.requester_id <= frame.requester_id;
      mem_req.tag          <= frame.tag;
      mem_req.dw_addr      <= frame.addr[BAR_ADDR_BITS-1:2];
      mem_req.data         <= (frame.kind == MWR) ? frame.data : '0; // Reads carry none
    end
    if (issue_instant) begin
      instant.has_data     <= ~frame.unsupported; // Zero-length read is a CplD
      instant.status       <= frame.unsupported ? CPL_STATUS_UR : CPL_STATUS_SC;
      instant.byte_count   <= frame.unsupported ? frame.byte_count : '0;
      instant.requester_id <= frame.requester_id;
      instant.tag          <= frame.tag;
      instant.lower_addr   <= frame.addr[6:0];
      instant.data         <= '0;
    end
    if (mem_resp_valid) begin
      response.has_data     <= 1'b1;
      response.status       <= CPL_STATUS_SC;
      response.byte_count   <= BC_BITS'(4); // Always one full dword
      response.requester_id <= mem_resp.requester_id;
      response.tag          <= mem_resp.tag;
      response.lower_addr   <= {mem_resp.lower_addr, 2'b00};
      response.data         <= mem_resp.rddata;
    end
  end

  // Memory side has no back-pressure path here
  a_mem_req_ready: assert property (@(posedge clk) disable iff (reset)
    mem_req_valid |-> mem_req_ready)
    else $error("mem_req issued while mem_req_ready low");

endmodule

`default_nettype wire

//--- logic/tlp_cpl_framer.sv
/* Completion framer
   Packs a completion record into one registered 256-bit TX beat */
`default_nettype none

module tlp_cpl_framer (
  input  logic                          clk,
  input  logic                          reset,
  input  logic [tlp_pkg::ID_BITS-1:0]   completer_id,
  input  tlp_pkg::cpl_fields_t          cpl,
  input  logic                          cpl_valid,
  output tlp_pkg::tx_beat_t             tx
);
  import tlp_pkg::*;

  logic [BEAT_DWORDS-1:0][DW_BITS-1:0] dw;
  logic [BEAT_BITS-1:0]  beat_data;
  logic [EMPTY_BITS-1:0] beat_empty;
  logic [5:0]            code;
  logic                  payload;
  logic [BEAT_BITS-1:0]  tx_data;
  logic [EMPTY_BITS-1:0] tx_empty;
  logic                  tx_strobe;

  assign code    = cpl.has_data ? FMT_TYPE_CPLD : FMT_TYPE_CPL;
  assign payload = cpl.has_data & (cpl.byte_count != '0); // Zero-length CplD has none

  always_comb begin
    dw       = '0;
    dw[0]    = {1'b0, code[5], 1'b0, code[4:0], 23'd0, payload}; // 3DW, length 0 or 1
    dw[1]    = {completer_id, cpl.status, 1'b0, cpl.byte_count};
    dw[2]    = {cpl.requester_id, cpl.tag, 1'b0, cpl.lower_addr};
    beat_empty = EMPTY_BITS'(20); // Header only
    if (payload) begin
      // Qword-aligned lower address gets a pad dword first
      if (cpl.lower_addr[2]) begin
        dw[3]      = cpl.data;
        beat_empty = EMPTY_BITS'(16);
      end else begin
        dw[4]      = cpl.data;
        beat_empty = EMPTY_BITS'(12);
      end
    end
    for (int i = 0; i < BEAT_DWORDS; i++) begin
      beat_data[BEAT_BITS-1-i*DW_BITS -: DW_BITS] = dw[i]; // Dword 0 on top
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      tx_strobe <= 1'b0;
    end else begin
      tx_strobe <= cpl_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (cpl_valid) begin
      tx_data  <= beat_data;
      tx_empty <= beat_empty;
    end
  end

  // Single-beat TLP
  assign tx = '{data: tx_data, empty: tx_empty, valid: tx_strobe, sop: tx_strobe,
                eop: tx_strobe};

  // A CplD record must fit one dword and be successful
  a_single_dword: assert property (@(posedge clk) disable iff (reset)
    cpl_valid && cpl.has_data |-> cpl.status == CPL_STATUS_SC &&
                                  cpl.byte_count <= BC_BITS'(4))
    else $error("CplD record does not fit a single-dword completion beat");

endmodule

`default_nettype wire

//--- logic/tlp_stats_csr.sv
/* TLP statistics and CSR
   Counts RX and TX TLPs, registered read port for status and counters */
`default_nettype none

module tlp_stats_csr (
  input  logic                              clk,
  input  logic                              reset,
  input  logic [tlp_pkg::ID_BITS-1:0]       completer_id,
  input  logic                              id_valid,
  input  logic                              rx_sop_accepted,
  input  logic                              frame_end,
  input  logic                              frame_unsupported,
  input  tlp_pkg::tx_beat_t                 tx_instant,
  input  tlp_pkg::tx_beat_t                 tx_response,
  input  logic                              csr_read,
  input  logic [tlp_pkg::CSR_ADDR_BITS-1:0] csr_address,
  output logic [tlp_pkg::DW_BITS-1:0]       csr_readdata
);
  import tlp_pkg::*;

  logic [DW_BITS-1:0] rx_count;
  logic [DW_BITS-1:0] rx_unsup_count;
  logic [DW_BITS-1:0] tx_instant_count;
  logic [DW_BITS-1:0] tx_response_count;

  always_ff @(posedge clk) begin
    if (reset) begin
      rx_count          <= '0;
      rx_unsup_count    <= '0;
      tx_instant_count  <= '0;
      tx_response_count <= '0;
    end else begin
      if (rx_sop_accepted) rx_count <= rx_count + 1'b1;
      if (frame_end && frame_unsupported) rx_unsup_count <= rx_unsup_count + 1'b1;
      if (tx_instant.valid && tx_instant.sop) begin
        tx_instant_count <= tx_instant_count + 1'b1;
      end
      if (tx_response.valid && tx_response.sop) begin
        tx_response_count <= tx_response_count + 1'b1;
      end
    end
  end

  // Read data holds until the next read
  always_ff @(posedge clk) begin
    if (reset) begin
      csr_readdata <= '0;
    end else if (csr_read) begin
      case (csr_address)
        CSR_STATUS:            csr_readdata <= {15'd0, id_valid, completer_id};
        CSR_RX_COUNT:          csr_readdata <= rx_count;
        CSR_RX_UNSUP_COUNT:    csr_readdata <= rx_unsup_count;
        CSR_TX_INSTANT_COUNT:  csr_readdata <= tx_instant_count;
        CSR_TX_RESPONSE_COUNT: csr_readdata <= tx_response_count;
        default:               csr_readdata <= CSR_UNMAPPED;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- logic/pcie_tlp_handler.sv
/* PCIe endpoint TLP handler top
   RX decode, dispatch, instant and response completion framers, statistics */
`default_nettype none

module pcie_tlp_handler (
  input  logic                              clk,
  input  logic                              reset,
  input  logic [tlp_pkg::ID_BITS-1:0]       completer_id,
  input  logic                              id_valid,
  input  tlp_pkg::rx_beat_t                 rx_st,
  input  logic                              rx_valid,
  output logic                              rx_ready,
  output tlp_pkg::mem_req_t                 mem_req,
  output logic                              mem_req_valid,
  input  logic                              mem_req_ready,
  input  tlp_pkg::mem_resp_t                mem_resp,
  input  logic                              mem_resp_valid,
  output logic                              mem_resp_ready,
  output tlp_pkg::tx_beat_t                 tx_instant,
  output tlp_pkg::tx_beat_t                 tx_response,
  output logic [6:0]                        cpl_err,
  input  logic                              csr_read,
  input  logic [tlp_pkg::CSR_ADDR_BITS-1:0] csr_address,
  output logic [tlp_pkg::DW_BITS-1:0]       csr_readdata
);
  import tlp_pkg::*;

  logic        accept;
  logic        resp_accept;
  rx_frame_t   frame;
  logic        frame_end;
  cpl_fields_t instant;
  logic        instant_valid;
  cpl_fields_t response;
  logic        response_valid;

  // Work only once the completer ID is known
  assign rx_ready       = id_valid;
  assign mem_resp_ready = id_valid;
  assign accept         = rx_valid & id_valid;
  assign resp_accept    = mem_resp_valid & id_valid;

  tlp_rx_decode u_rx_decode (
    .clk         (clk),
    .reset       (reset),
    .accept      (accept),
    .rx_st       (rx_st),
    .frame       (frame),
    .frame_start (),
    .frame_end   (frame_end),
    .cpl_err     (cpl_err)
  );

  tlp_dispatch u_dispatch (
    .clk            (clk),
    .reset          (reset),
    .frame          (frame),
    .frame_end      (frame_end),
    .mem_resp       (mem_resp),
    .mem_resp_valid (resp_accept),
    .mem_req_ready  (mem_req_ready),
    .mem_req        (mem_req),
    .mem_req_valid  (mem_req_valid),
    .instant        (instant),
    .instant_valid  (instant_valid),
    .response       (response),
    .response_valid (response_valid)
  );

  tlp_cpl_framer u_instant_framer (
    .clk          (clk),
    .reset        (reset),
    .completer_id (completer_id),
    .cpl          (instant),
    .cpl_valid    (instant_valid),
    .tx           (tx_instant)
  );

  tlp_cpl_framer u_response_framer (
    .clk          (clk),
    .reset        (reset),
    .completer_id (completer_id),
    .cpl          (response),
    .cpl_valid    (response_valid),
    .tx           (tx_response)
  );

  tlp_stats_csr u_stats_csr (
    .clk               (clk),
    .reset             (reset),
    .completer_id      (completer_id),
    .id_valid          (id_valid),
    .rx_sop_accepted   (accept & rx_st.sop),
    .frame_end         (frame_end),
    .frame_unsupported (frame.unsupported),
    .tx_instant        (tx_instant),
    .tx_response       (tx_response),
    .csr_read          (csr_read),
    .csr_address       (csr_address),
    .csr_readdata      (csr_readdata)
  );

endmodule

`default_nettype wire

//--- include/tlp_model.svh
/* TLP reference model
   Expected byte count and completion beat built from request fields */
`ifndef TLP_MODEL_SVH
`define TLP_MODEL_SVH
`default_nettype none

// Byte lanes 0-3 from first BE, 4-7 from last BE
function automatic logic [11:0] model_byte_count(
    input logic [3:0] first_be,
    input logic [3:0] last_be,
    input logic [9:0] len);
  logic [7:0] lanes;
  int lo;
  int hi;
  lanes = {last_be, first_be};
  lo = -1;
  hi = -1;
  for (int i = 0; i < 8; i++) begin
    if (lanes[i] && lo < 0) lo = i;
    if (lanes[i]) hi = i;
  end
  if (first_be == 4'b0000) return 12'd0; // Zero-length or invalid
  if (last_be == 4'b0000) return 12'(hi - lo + 1);
  return 12'(int'({len, 2'b00}) - lo - (7 - hi));
endfunction

function automatic tlp_pkg::tx_beat_t model_cpl_beat(
    input logic [15:0] completer_id,
    input tlp_pkg::cpl_fields_t c);
  tlp_pkg::tx_beat_t beat;
  logic payload;
  int slot;
  payload = c.has_data && (c.byte_count != 12'd0);
  slot = c.lower_addr[2] ? 3 : 4; // Pad dword when qword aligned
  beat.data = {1'b0, c.has_data, 1'b0, 5'b01010, 23'd0, payload,
               completer_id, c.status, 1'b0, c.byte_count,
               c.requester_id, c.tag, 1'b0, c.lower_addr, 160'd0};
  if (payload) beat.data[255-32*slot -: 32] = c.data;
  beat.empty = payload ? (c.lower_addr[2] ? 5'd16 : 5'd12) : 5'd20;
  beat.valid = 1'b1;
  beat.sop = 1'b1;
  beat.eop = 1'b1;
  return beat;
endfunction

`default_nettype wire
`endif

//--- tests/tb_pcie_tlp_handler.sv
/* TLP handler testbench
   Random single-beat requests and memory responses checked against a reference model */
`include "tlp_model.svh"
`default_nettype none

module tb_pcie_tlp_handler;
  timeunit 1ns;
  timeprecision 1ps;
  import tlp_pkg::*;

  localparam int NUM_TXN     = 400;
  localparam int CLK_PERIOD  = 100;
  localparam int WATCHDOG_NS = NUM_TXN * 6 * CLK_PERIOD;

  logic                     clk;
  logic                     reset;
  logic [ID_BITS-1:0]       completer_id;
  logic                     id_valid;
  rx_beat_t                 rx_st;
  logic                     rx_valid;
  logic                     rx_ready;
  mem_req_t                 mem_req;
  logic                     mem_req_valid;
  logic                     mem_req_ready;
  mem_resp_t                mem_resp;
  logic                     mem_resp_valid;
  logic                     mem_resp_ready;
  tx_beat_t                 tx_instant;
  tx_beat_t                 tx_response;
  logic [6:0]               cpl_err;
  logic                     csr_read;
  logic [CSR_ADDR_BITS-1:0] csr_address;
  logic [DW_BITS-1:0]       csr_readdata;

  mem_req_t    exp_mem_q[$];      // Expected memory requests, in order
  tx_beat_t    exp_instant_q[$];
  tx_beat_t    exp_response_q[$];
  logic [6:0]  exp_err_drive;     // cpl_err expected for the beat being driven
  logic [6:0]  exp_err_stage;     // Same, one edge later
  int unsigned n_rx;
  int unsigned n_unsup;
  int unsigned n_instant;
  int unsigned n_response;

  pcie_tlp_handler u_dut (
    .clk            (clk),
    .reset          (reset),
    .completer_id   (completer_id),
    .id_valid       (id_valid),
    .rx_st          (rx_st),
    .rx_valid       (rx_valid),
    .rx_ready       (rx_ready),
    .mem_req        (mem_req),
    .mem_req_valid  (mem_req_valid),
    .mem_req_ready  (mem_req_ready),
    .mem_resp       (mem_resp),
    .mem_resp_valid (mem_resp_valid),
    .mem_resp_ready (mem_resp_ready),
    .tx_instant     (tx_instant),
    .tx_response    (tx_response),
    .cpl_err        (cpl_err),
    .csr_read       (csr_read),
    .csr_address    (csr_address),
    .csr_readdata   (csr_readdata)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  // Inputs change 10 ns after the edge
  task automatic next_cycle();
    @(posedge clk);
    #10;
  endtask

  // One random single-beat request, expectations recorded only if it is taken
  task automatic send_random_tlp();
    logic [2:0]  fmt;
    logic [4:0]  ftype;
    logic [9:0]  len;
    logic [3:0]  fbe;
    logic [3:0]  lbe;
    logic [15:0] rid;
    logic [7:0]  tag;
    logic [31:0] wdata;
    logic [31:0] dw [8];
    logic        write;
    logic        is_mem;
    logic        is_npr;
    logic        is_pr;
    logic        unsup;
    logic [11:0] bc;
    int          sel;
    mem_req_t    req;
    cpl_fields_t cpl;
    fmt    = 3'b000; // 3DW MRd unless changed
    ftype  = 5'b00000;
    len    = 10'd1;
    fbe    = 4'hf;
    lbe    = 4'h0;
    rid    = 16'($urandom);
    tag    = 8'($urandom);
    wdata  = $urandom;
    write  = 1'($urandom_range(0, 1));
    is_mem = 1'b1;
    is_npr = 1'b1;
    is_pr  = 1'b0;
    sel    = $urandom_range(0, 9);
    case (sel)
      0, 1: write = 1'b1;
      2, 3: write = 1'b0;
      4: begin
        write = 1'b0;
        fbe   = 4'h0; // Zero-length read
      end
      5: begin
        len = 10'($urandom_range(2, 16));
        lbe = 4'($urandom_range(1, 15));
      end
      6: fbe = 4'($urandom_range(1, 14)); // Partial enables
      7: begin
        write  = 1'b0;
        ftype  = 5'b00001; // MRdLk
        is_mem = 1'b0;
      end
      8: fmt[0] = 1'b1; // 4DW header
      default: begin
        write  = 1'b0;
        is_mem = 1'b0;
        case ($urandom_range(0, 2))
          0: ftype = 5'b00010; // IO read, non-posted
          1: begin
            fmt    = 3'b001; // Msg
            ftype  = 5'b10000;
            is_npr = 1'b0;
            is_pr  = 1'b1;
          end
          default: begin
            ftype  = 5'b01010; // Cpl, neither class
            is_npr = 1'b0;
          end
        endcase
      end
    endcase
    if (write) begin
      fmt[1] = 1'b1;
      is_npr = 1'b0;
      is_pr  = 1'b1;
    end
    for (int i = 0; i < 8; i++) dw[i] = $urandom; // Junk in unused dwords
    dw[0] = {fmt, ftype, 14'd0, len};
    dw[1] = {rid, tag, lbe, fbe};
    dw[2] = $urandom & 32'hffff_fffc;
    if (write && !fmt[0]) begin
      if (dw[2][2]) dw[3] = wdata;
      else dw[4] = wdata; // Pad dword in front
    end
    for (int i = 0; i < 8; i++) rx_st.data[255 - 32*i -: 32] = dw[i];
    rx_st.empty = write ? 5'd12 : 5'd20;
    rx_st.sop   = 1'b1;
    rx_st.eop   = 1'b1;
    rx_valid    = 1'b1;

    bc    = model_byte_count(fbe, lbe, len);
    unsup = !is_mem || fmt[0] || len != 10'd1 || (bc != 12'd0 && bc != 12'd4);
    exp_err_drive = '0;
    if (!id_valid) return;
    n_rx++;
    if (unsup) n_unsup++;
    exp_err_drive[CPL_ERR_UR_P_BIT]  = unsup & is_pr;
    exp_err_drive[CPL_ERR_UR_NP_BIT] = unsup & is_npr;
    if (!unsup && is_mem && bc != 12'd0) begin
      req.is_write     = write;
      req.requester_id = rid;
      req.tag          = tag;
      req.dw_addr      = dw[2][15:2]; // Masked to 64 KiB
      req.data         = write ? wdata : 32'd0;
      exp_mem_q.push_back(req);
    end
    if (is_npr && (unsup || bc == 12'd0)) begin
      cpl.has_data     = !unsup;
      cpl.status       = unsup ? CPL_STATUS_UR : CPL_STATUS_SC;
      cpl.byte_count   = unsup ? bc : 12'd0;
      cpl.requester_id = rid;
      cpl.tag          = tag;
      cpl.lower_addr   = dw[2][6:0];
      cpl.data         = 32'd0;
      exp_instant_q.push_back(model_cpl_beat(completer_id, cpl));
      n_instant++;
    end
  endtask

  task automatic drive_random_resp();
    cpl_fields_t cpl;
    mem_resp_valid          = ($urandom_range(0, 3) == 0);
    mem_resp.requester_id   = 16'($urandom);
    mem_resp.tag            = 8'($urandom);
    mem_resp.lower_addr     = 5'($urandom);
    mem_resp.rddata         = $urandom;
    if (mem_resp_valid && id_valid) begin
      cpl.has_data     = 1'b1;
      cpl.status       = CPL_STATUS_SC;
      cpl.byte_count   = 12'd4; // One full dword
      cpl.requester_id = mem_resp.requester_id;
      cpl.tag          = mem_resp.tag;
      cpl.lower_addr   = {mem_resp.lower_addr, 2'b00};
      cpl.data         = mem_resp.rddata;
      exp_response_q.push_back(model_cpl_beat(completer_id, cpl));
      n_response++;
    end
  endtask

  task automatic check_csr(input logic [CSR_ADDR_BITS-1:0] addr, input logic [31:0] exp,
                           input string name);
    next_cycle();
    csr_read    = 1'b1;
    csr_address = addr;
    next_cycle();
    csr_read = 1'b0;
    @(negedge clk);
    assert (csr_readdata === exp)
      else stop_on_error($sformatf("Fail csr_readdata (%s) got %h expected %h",
                                   name, csr_readdata, exp));
    @(negedge clk);
    assert (csr_readdata === exp) // Holds until next read
      else stop_on_error($sformatf("Fail csr_readdata (%s) not held, got %h expected %h",
                                   name, csr_readdata, exp));
  endtask

  always @(posedge clk) exp_err_stage <= exp_err_drive;

  // Outputs compared mid-cycle
  always @(negedge clk) begin
    assert (rx_ready === id_valid && mem_resp_ready === id_valid)
      else stop_on_error($sformatf("Fail rx_ready %h mem_resp_ready %h with id_valid %h",
                                   rx_ready, mem_resp_ready, id_valid));
    if (!reset) begin
      assert (cpl_err === exp_err_stage)
        else stop_on_error($sformatf("Fail cpl_err got %h expected %h", cpl_err, exp_err_stage));
      if (mem_req_valid) begin
        assert (exp_mem_q.size() != 0)
          else stop_on_error("A memory request came out that no received TLP called for");
        assert (mem_req === exp_mem_q[0])
          else stop_on_error($sformatf("Fail mem_req got %h expected %h", mem_req, exp_mem_q[0]));
        void'(exp_mem_q.pop_front());
      end
      if (tx_instant.valid) begin
        assert (exp_instant_q.size() != 0)
          else stop_on_error("A completion came out on the instant port without a cause");
        assert (tx_instant === exp_instant_q[0])
          else stop_on_error($sformatf("Fail tx_instant got %h expected %h",
                                       tx_instant, exp_instant_q[0]));
        void'(exp_instant_q.pop_front());
      end
      if (tx_response.valid) begin
        assert (exp_response_q.size() != 0)
          else stop_on_error("A completion came out on the response port without a cause");
        assert (tx_response === exp_response_q[0])
          else stop_on_error($sformatf("Fail tx_response got %h expected %h",
                                       tx_response, exp_response_q[0]));
        void'(exp_response_q.pop_front());
      end
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired before all transactions completed");
    $display("TEST FAILED");
    $fatal(1);
  end

  initial begin
    void'($urandom(23));
    clk            = 1'b0;
    reset          = 1'b1;
    completer_id   = 16'($urandom);
    id_valid       = 1'b0;
    rx_st          = '0;
    rx_valid       = 1'b0;
    mem_req_ready  = 1'b1;
    mem_resp       = '0;
    mem_resp_valid = 1'b0;
    csr_read       = 1'b0;
    csr_address    = '0;
    exp_err_drive  = '0;
    exp_err_stage  = '0;
    n_rx           = 0;
    n_unsup        = 0;
    n_instant      = 0;
    n_response     = 0;
    repeat (8) @(posedge clk);
    #10;
    reset = 1'b0;

    // No completer ID yet, so nothing may be taken
    repeat (10) begin
      next_cycle();
      send_random_tlp();
      drive_random_resp();
    end
    next_cycle();
    rx_valid       = 1'b0;
    mem_resp_valid = 1'b0;
    id_valid       = 1'b1;

    repeat (NUM_TXN) begin
      next_cycle();
      if ($urandom_range(0, 9) < 7) begin
        send_random_tlp();
      end else begin
        rx_valid      = 1'b0;
        exp_err_drive = '0;
      end
      drive_random_resp();
    end
    next_cycle();
    rx_valid       = 1'b0;
    mem_resp_valid = 1'b0;
    exp_err_drive  = '0;

    while (exp_mem_q.size() != 0 || exp_instant_q.size() != 0 ||
           exp_response_q.size() != 0) begin
      @(posedge clk);
    end
    repeat (4) @(posedge clk);

    check_csr(CSR_STATUS, {15'd0, 1'b1, completer_id}, "status");
    check_csr(CSR_RX_COUNT, n_rx, "rx count");
    check_csr(CSR_RX_UNSUP_COUNT, n_unsup, "unsupported count");
    check_csr(CSR_TX_INSTANT_COUNT, n_instant, "instant count");
    check_csr(CSR_TX_RESPONSE_COUNT, n_response, "response count");
    check_csr(6'd41, 32'hffff_ffff, "unmapped");

    $display("TEST PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
+incdir+include
logic/tlp_pkg.sv
logic/tlp_rx_decode.sv
logic/tlp_dispatch.sv
logic/tlp_cpl_framer.sv
logic/tlp_stats_csr.sv
logic/pcie_tlp_handler.sv
tests/tb_pcie_tlp_handler.sv

//--- Makefile
TB_TOP  = tb_pcie_tlp_handler
RTL_TOP = pcie_tlp_handler

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f files.f --top-module $(RTL_TOP)
	verilator --lint-only --timing --assert -f files.f --top-module $(TB_TOP)

sim:
	verilator --binary --timing --assert -j 0 -f files.f --top-module $(TB_TOP) \
		-o sim_$(TB_TOP)
	./obj_dir/sim_$(TB_TOP) | tee sim.log
	grep -q "TEST PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
